// File: Bender.yml
package:
  name: rv_ctrl_pipe

sources:
  - files:
      - hw/rv_ctrl_pkg.sv
      - hw/decode_stage.sv
      - hw/exec_ctrl_stage.sv
      - hw/wb_ctrl_stage.sv
      - hw/rv_ctrl_pipe.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/rv_ctrl_pipe_tb.sv

// File: include/rv_ctrl_vectors.svh
// Stimulus and expected-control table for the control pipeline testbench
// Entry i is in execute one cycle after it is applied and in write-back two cycles after
`ifndef RV_CTRL_VECTORS_SVH
`define RV_CTRL_VECTORS_SVH

typedef struct packed {
  logic [rv_ctrl_pkg::XLEN-1:0]   inst;
  logic                           valid;
  logic                           br_eq;     // Driven while the entry is in execute
  logic                           br_lt;
  rv_ctrl_pkg::exec_ctrl_t        x_ctrl;    // alu_op, a_sel, b_sel, br_un, fwd_a, fwd_b
  logic                           br_taken;
  rv_ctrl_pkg::wb_ctrl_t          wb_ctrl;   // rf_we, wb_sel, ld_sel
  logic [rv_ctrl_pkg::REG_AW-1:0] wb_rd;
  logic                           pc_sel;
} ctrl_vec_t;

localparam int NUM_VECTORS = 42;

localparam ctrl_vec_t VECTORS [NUM_VECTORS] = '{
    '{32'h00000000, 1'b0, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    // ADD, SUB, SRA, SLTU, then SRAI, ORI, SLLI
    '{32'h003100B3, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd1, 1'b0},
    '{32'h40628233, 1'b1, 1'b0, 1'b0, 10'b0001_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd4, 1'b0},
    '{32'h409453B3, 1'b1, 1'b0, 1'b0, 10'b0111_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd7, 1'b0},
    '{32'h00C5B533, 1'b1, 1'b0, 1'b0, 10'b1001_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd10, 1'b0},
    '{32'h40375693, 1'b1, 1'b0, 1'b0, 10'b0111_00_1_0_0_0, 1'b0, 6'b1_01_000, 5'd13, 1'b0},
    // Immediate bits 24:20 match the previous rd, no rs2 use
    '{32'h0ED86793, 1'b1, 1'b0, 1'b0, 10'b0011_00_1_0_0_0, 1'b0, 6'b1_01_000, 5'd15, 1'b0},
    '{32'h00491893, 1'b1, 1'b0, 1'b0, 10'b0101_00_1_0_0_0, 1'b0, 6'b1_01_000, 5'd17, 1'b0},
    // BEQ, BNE, BLT, BGE, BLTU, BGEU, each taken and then not taken
    '{32'h015A0463, 1'b1, 1'b1, 1'b0, 10'b0000_01_1_0_0_0, 1'b1, 6'b0_01_000, 5'd0, 1'b1},
    '{32'h015A0463, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h015A1463, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_0_0_0, 1'b1, 6'b0_01_000, 5'd0, 1'b1},
    '{32'h015A1463, 1'b1, 1'b1, 1'b0, 10'b0000_01_1_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h015A4463, 1'b1, 1'b0, 1'b1, 10'b0000_01_1_0_0_0, 1'b1, 6'b0_01_000, 5'd0, 1'b1},
    '{32'h015A4463, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h015A5463, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_0_0_0, 1'b1, 6'b0_01_000, 5'd0, 1'b1},
    '{32'h015A5463, 1'b1, 1'b0, 1'b1, 10'b0000_01_1_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h015A6463, 1'b1, 1'b0, 1'b1, 10'b0000_01_1_1_0_0, 1'b1, 6'b0_01_000, 5'd0, 1'b1},
    '{32'h015A6463, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_1_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h015A7463, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_1_0_0, 1'b1, 6'b0_01_000, 5'd0, 1'b1},
    '{32'h015A7463, 1'b1, 1'b0, 1'b1, 10'b0000_01_1_1_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    // LB, LBU, LH, LHU, LW, SW, JAL, JALR, AUIPC, LUI
    '{32'h000B8B03, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b1_00_100, 5'd22, 1'b0},
    '{32'h000CCC03, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b1_00_011, 5'd24, 1'b0},
    '{32'h000D9D03, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b1_00_010, 5'd26, 1'b0},
    '{32'h000EDE03, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b1_00_001, 5'd28, 1'b0},
    '{32'h000FAF03, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b1_00_000, 5'd30, 1'b0},
    '{32'h00112023, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h010000EF, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_0_0_0, 1'b0, 6'b1_10_000, 5'd1, 1'b1},
    '{32'h000302E7, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b1_10_000, 5'd5, 1'b1},
    '{32'h12345397, 1'b1, 1'b0, 1'b0, 10'b0000_01_1_0_0_0, 1'b0, 6'b1_01_000, 5'd7, 1'b0},
    // Immediate bits 19:15 match the previous rd, no rs1 use
    '{32'hABC3E437, 1'b1, 1'b0, 1'b0, 10'b0000_10_1_0_0_0, 1'b0, 6'b1_01_000, 5'd8, 1'b0},
    // Forward to rs1, then to rs2
    '{32'h002084B3, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd9, 1'b0},
    '{32'h00348533, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_1_0, 1'b0, 6'b1_01_000, 5'd10, 1'b0},
    '{32'h40A205B3, 1'b1, 1'b0, 1'b0, 10'b0001_00_0_0_0_1, 1'b0, 6'b1_01_000, 5'd11, 1'b0},
    // No forwarding from x0, from a store or across a bubble
    '{32'h00208033, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd0, 1'b0},
    '{32'h00000633, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd12, 1'b0},
    '{32'h00322223, 1'b1, 1'b0, 1'b0, 10'b0000_00_1_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h005206B3, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd13, 1'b0},
    '{32'h00000000, 1'b0, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h00D68733, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd14, 1'b0},
    // ECALL decodes as illegal
    '{32'h00000073, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0},
    '{32'h001707B3, 1'b1, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b1_01_000, 5'd15, 1'b0},
    '{32'h00000000, 1'b0, 1'b0, 1'b0, 10'b0000_00_0_0_0_0, 1'b0, 6'b0_01_000, 5'd0, 1'b0}
};

`endif

// File: dv/rv_ctrl_pipe_tb.sv
// Testbench for the control pipeline: clock, reset, table-driven
// stimulus loop and checks of execute and write-back controls
`timescale 1ns/10ps

module rv_ctrl_pipe_tb;

  `include "rv_ctrl_vectors.svh"

  localparam int MAX_CYCLES = 200;  // Watchdog limit

  logic                           clk;
  logic                           rst;
  logic                           inst_valid;
  logic [rv_ctrl_pkg::XLEN-1:0]   inst;
  logic                           br_eq;
  logic                           br_lt;
  rv_ctrl_pkg::exec_ctrl_t        x_ctrl;
  logic                           br_taken;
  rv_ctrl_pkg::wb_ctrl_t          wb_ctrl;
  logic [rv_ctrl_pkg::REG_AW-1:0] wb_rd;
  rv_ctrl_pkg::pc_sel_e           pc_sel;

  rv_ctrl_pipe DUT (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .br_eq      (br_eq),
    .br_lt      (br_lt),
    .x_ctrl     (x_ctrl),
    .br_taken   (br_taken),
    .wb_ctrl    (wb_ctrl),
    .wb_rd      (wb_rd),
    .pc_sel     (pc_sel)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected)
    else begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Entry idx sits in execute during this cycle
  task automatic check_exec(input int idx);
    check_value($sformatf("vector %0d x_ctrl", idx), VECTORS[idx].x_ctrl, x_ctrl);
    check_value($sformatf("vector %0d br_taken", idx), VECTORS[idx].br_taken, br_taken);
  endtask

  // Entry idx sits in write-back during this cycle
  task automatic check_wb(input int idx);
    check_value($sformatf("vector %0d wb_ctrl", idx), VECTORS[idx].wb_ctrl, wb_ctrl);
    check_value($sformatf("vector %0d wb_rd", idx), VECTORS[idx].wb_rd, wb_rd);
    check_value($sformatf("vector %0d pc_sel", idx), VECTORS[idx].pc_sel, pc_sel);
  endtask

  // New word for entry k, branch flags for the entry now in execute
  task automatic drive_step(input int k);
    if (k < NUM_VECTORS) begin
      inst       = VECTORS[k].inst;
      inst_valid = VECTORS[k].valid;
    end else begin
      inst       = '0;
      inst_valid = 1'b0;
    end
    if (k >= 1 && k <= NUM_VECTORS) begin
      br_eq = VECTORS[k-1].br_eq;
      br_lt = VECTORS[k-1].br_lt;
    end else begin
      br_eq = 1'b0;
      br_lt = 1'b0;
    end
  endtask

  initial begin
    int k;
    clk         = 1'b0;
    rst         = 1'b1;
    inst_valid  = 1'b0;
    inst        = '0;
    br_eq       = 1'b0;
    br_lt       = 1'b0;
    for (k = 0; k < 2; k++) begin  // Two reset cycles
      @(posedge clk);
    end
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value("reset x_ctrl", '0, x_ctrl);  // Neutral encoding is all zero
    check_value("reset br_taken", 1'b0, br_taken);
    check_value("reset rf_we", 1'b0, wb_ctrl.rf_we);
    check_value("reset pc_sel", rv_ctrl_pkg::PC_SEQ, pc_sel);
    for (k = 0; k < NUM_VECTORS + 2; k++) begin
      @(posedge clk);
      #2;
      drive_step(k);
      @(negedge clk);  // Outputs settled mid-cycle
      if (k >= 1 && k <= NUM_VECTORS) begin
        check_exec(k - 1);
      end
      if (k >= 2) begin
        check_wb(k - 2);
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog
  initial begin
    int cycle;
    for (cycle = 0; cycle < MAX_CYCLES; cycle++) begin
      @(posedge clk);
    end
    $display("Timeout: the test did not finish within %0d clock cycles", MAX_CYCLES);
    stop_on_failure();
  end

endmodule

// File: files.f
+incdir+include
hw/rv_ctrl_pkg.sv
hw/decode_stage.sv
hw/exec_ctrl_stage.sv
hw/wb_ctrl_stage.sv
hw/rv_ctrl_pipe.sv
dv/rv_ctrl_pipe_tb.sv

// File: hw/decode_stage.sv
// Decode stage: instruction register, opcode mapping and
// register-use flags for the decode-to-execute record
`timescale 1ns/10ps

module decode_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inst_valid,
  input  logic [rv_ctrl_pkg::XLEN-1:0] inst,
  output rv_ctrl_pkg::dec_t            dec
);

  rv_ctrl_pkg::opcode_e op;
  logic                 uses_rs1;
  logic                 uses_rs2;

  always_comb begin
    if (inst[1:0] != 2'b11) begin  // Compressed or malformed word
      op = rv_ctrl_pkg::OP_ILLEGAL;
    end else begin
      case (inst[6:2])
        rv_ctrl_pkg::OP_REG,
        rv_ctrl_pkg::OP_IMM,
        rv_ctrl_pkg::OP_LOAD,
        rv_ctrl_pkg::OP_STORE,
        rv_ctrl_pkg::OP_BRANCH,
        rv_ctrl_pkg::OP_JAL,
        rv_ctrl_pkg::OP_JALR,
        rv_ctrl_pkg::OP_AUIPC,
        rv_ctrl_pkg::OP_LUI: op = rv_ctrl_pkg::opcode_e'(inst[6:2]);
        default:             op = rv_ctrl_pkg::OP_ILLEGAL;  // SYSTEM, FENCE and the rest
      endcase
    end
  end

  always_comb begin
    case (op)
      rv_ctrl_pkg::OP_JAL,
      rv_ctrl_pkg::OP_AUIPC,
      rv_ctrl_pkg::OP_LUI,
      rv_ctrl_pkg::OP_ILLEGAL: uses_rs1 = 1'b0;
      default:                 uses_rs1 = 1'b1;
    endcase
    case (op)
      rv_ctrl_pkg::OP_REG,
      rv_ctrl_pkg::OP_STORE,
      rv_ctrl_pkg::OP_BRANCH: uses_rs2 = 1'b1;
      default:                uses_rs2 = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin  // Fields hold across bubbles
      dec.op       <= op;
      dec.funct3   <= inst[14:12];
      dec.alt      <= inst[30];
      dec.rd       <= inst[11:7];
      dec.rs1      <= inst[19:15];
      dec.rs2      <= inst[24:20];
      dec.uses_rs1 <= uses_rs1;
      dec.uses_rs2 <= uses_rs2;
    end
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= inst_valid;
    end
  end

endmodule

// File: hw/exec_ctrl_stage.sv
// Execute control: ALU and operand selects, branch resolution,
// write-back forwarding and the execute-to-write-back register
`timescale 1ns/10ps

module exec_ctrl_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_ctrl_pkg::dec_t       dec,
  input  logic                    br_eq,
  input  logic                    br_lt,
  output rv_ctrl_pkg::exec_ctrl_t x_ctrl,
  output logic                    br_taken,
  output rv_ctrl_pkg::wb_t        wb
);

  rv_ctrl_pkg::alu_op_e alu_dec;
  logic                 br_cond;
  logic                 wb_hit;
  logic                 redirect;
  logic                 rf_we;
  logic                 legal;

  assign legal = dec.valid && (dec.op != rv_ctrl_pkg::OP_ILLEGAL);

  // Shared funct3 decode for register and immediate arithmetic
  always_comb begin
    case (dec.funct3)
      3'b000: begin
        if (dec.alt && (dec.op == rv_ctrl_pkg::OP_REG)) begin
          alu_dec = rv_ctrl_pkg::ALU_SUB;  // ADDI never subtracts
        end else begin
          alu_dec = rv_ctrl_pkg::ALU_ADD;
        end
      end
      3'b001:  alu_dec = rv_ctrl_pkg::ALU_SLL;
      3'b010:  alu_dec = rv_ctrl_pkg::ALU_SLT;
      3'b011:  alu_dec = rv_ctrl_pkg::ALU_SLTU;
      3'b100:  alu_dec = rv_ctrl_pkg::ALU_XOR;
      3'b101:  alu_dec = dec.alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
      3'b110:  alu_dec = rv_ctrl_pkg::ALU_OR;
      default: alu_dec = rv_ctrl_pkg::ALU_AND;
    endcase
  end

  // Producer in write-back that actually writes a real register
  assign wb_hit = wb.valid && wb.rf_we && (wb.rd != '0);

  always_comb begin
    x_ctrl.alu_op = rv_ctrl_pkg::ALU_ADD;  // Neutral controls
    x_ctrl.a_sel  = rv_ctrl_pkg::A_RS1;
    x_ctrl.b_sel  = rv_ctrl_pkg::B_RS2;
    x_ctrl.br_un  = 1'b0;
    x_ctrl.fwd_a  = rv_ctrl_pkg::FWD_NONE;
    x_ctrl.fwd_b  = rv_ctrl_pkg::FWD_NONE;
    if (legal) begin
      if (dec.op == rv_ctrl_pkg::OP_REG || dec.op == rv_ctrl_pkg::OP_IMM) begin
        x_ctrl.alu_op = alu_dec;
      end
      case (dec.op)
        rv_ctrl_pkg::OP_BRANCH,
        rv_ctrl_pkg::OP_JAL,
        rv_ctrl_pkg::OP_AUIPC: x_ctrl.a_sel = rv_ctrl_pkg::A_PC;
        rv_ctrl_pkg::OP_LUI:   x_ctrl.a_sel = rv_ctrl_pkg::A_ZERO;
        default:               x_ctrl.a_sel = rv_ctrl_pkg::A_RS1;
      endcase
      if (dec.op != rv_ctrl_pkg::OP_REG) begin
        x_ctrl.b_sel = rv_ctrl_pkg::B_IMM;
      end
      x_ctrl.br_un = (dec.op == rv_ctrl_pkg::OP_BRANCH) &&
                     (dec.funct3 == rv_ctrl_pkg::F3_BLTU ||
                      dec.funct3 == rv_ctrl_pkg::F3_BGEU);
      if (wb_hit && dec.uses_rs1 && (wb.rd == dec.rs1)) begin
        x_ctrl.fwd_a = rv_ctrl_pkg::FWD_WB;
      end
      if (wb_hit && dec.uses_rs2 && (wb.rd == dec.rs2)) begin
        x_ctrl.fwd_b = rv_ctrl_pkg::FWD_WB;
      end
    end
  end

  always_comb begin
    case (dec.funct3)
      rv_ctrl_pkg::F3_BEQ:  br_cond = br_eq;
      rv_ctrl_pkg::F3_BNE:  br_cond = !br_eq;
      rv_ctrl_pkg::F3_BLT,
      rv_ctrl_pkg::F3_BLTU: br_cond = br_lt;   // Comparator follows br_un
      rv_ctrl_pkg::F3_BGE,
      rv_ctrl_pkg::F3_BGEU: br_cond = !br_lt;
      default:              br_cond = 1'b0;
    endcase
  end

  assign br_taken = dec.valid && (dec.op == rv_ctrl_pkg::OP_BRANCH) && br_cond;
  assign redirect = br_taken ||
                    (dec.valid && (dec.op == rv_ctrl_pkg::OP_JAL ||
                                   dec.op == rv_ctrl_pkg::OP_JALR));

  always_comb begin
    case (dec.op)
      rv_ctrl_pkg::OP_REG,
      rv_ctrl_pkg::OP_IMM,
      rv_ctrl_pkg::OP_LOAD,
      rv_ctrl_pkg::OP_JAL,
      rv_ctrl_pkg::OP_JALR,
      rv_ctrl_pkg::OP_AUIPC,
      rv_ctrl_pkg::OP_LUI: rf_we = dec.valid;
      default:             rf_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    wb.op     <= dec.op;
    wb.funct3 <= dec.funct3;
    wb.rd     <= dec.rd;
    if (rst) begin
      wb.valid    <= 1'b0;
      wb.rf_we    <= 1'b0;
      wb.redirect <= 1'b0;
    end else begin
      wb.valid    <= dec.valid;
      wb.rf_we    <= rf_we;
      wb.redirect <= redirect;
    end
  end

endmodule

// File: hw/rv_ctrl_pipe.sv
// Control pipeline top: decode, execute control and
// write-back control stages in a chain
`timescale 1ns/10ps

module rv_ctrl_pipe (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           inst_valid,
  input  logic [rv_ctrl_pkg::XLEN-1:0]   inst,
  input  logic                           br_eq,
  input  logic                           br_lt,
  output rv_ctrl_pkg::exec_ctrl_t        x_ctrl,
  output logic                           br_taken,
  output rv_ctrl_pkg::wb_ctrl_t          wb_ctrl,
  output logic [rv_ctrl_pkg::REG_AW-1:0] wb_rd,
  output rv_ctrl_pkg::pc_sel_e           pc_sel
);

  rv_ctrl_pkg::dec_t dec;  // Decode to execute
  rv_ctrl_pkg::wb_t  wb;   // Execute to write-back

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .dec        (dec)
  );

  exec_ctrl_stage u_exec (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .br_eq    (br_eq),
    .br_lt    (br_lt),
    .x_ctrl   (x_ctrl),
    .br_taken (br_taken),
    .wb       (wb)
  );

  wb_ctrl_stage u_wb (
    .wb      (wb),
    .wb_ctrl (wb_ctrl),
    .wb_rd   (wb_rd),
    .pc_sel  (pc_sel)
  );

endmodule

// File: hw/rv_ctrl_pkg.sv
// Shared widths, funct3 codes, control enums and stage records
// for the RV32I decode, execute and write-back control pipeline
package rv_ctrl_pkg;

  localparam int XLEN   = 32;  // Instruction word width
  localparam int REG_AW = 5;   // Register index width

  // Branch funct3 codes
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load funct3 codes
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD    = 5'b00000,
    OP_IMM     = 5'b00100,
    OP_AUIPC   = 5'b00101,
    OP_STORE   = 5'b01000,
    OP_REG     = 5'b01100,
    OP_LUI     = 5'b01101,
    OP_BRANCH  = 5'b11000,
    OP_JALR    = 5'b11001,
    OP_JAL     = 5'b11011,
    OP_ILLEGAL = 5'b11111   // Reserved pattern, never a legal RV32I opcode
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {A_RS1 = 2'd0, A_PC = 2'd1, A_ZERO = 2'd2} a_sel_e;
  typedef enum logic {B_RS2 = 1'b0, B_IMM = 1'b1} b_sel_e;
  typedef enum logic {FWD_NONE = 1'b0, FWD_WB = 1'b1} fwd_e;
  typedef enum logic [1:0] {WB_MEM = 2'd0, WB_ALU = 2'd1, WB_PC4 = 2'd2} wb_sel_e;
  typedef enum logic [2:0] {
    LD_W  = 3'd0,
    LD_UH = 3'd1,
    LD_SH = 3'd2,
    LD_UB = 3'd3,
    LD_SB = 3'd4
  } ld_sel_e;
  typedef enum logic {PC_SEQ = 1'b0, PC_TARGET = 1'b1} pc_sel_e;

  // Decode to execute record
  typedef struct packed {
    logic              valid;
    opcode_e           op;
    logic [2:0]        funct3;
    logic              alt;       // funct7 bit 5
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              uses_rs1;
    logic              uses_rs2;
  } dec_t;

  typedef struct packed {
    alu_op_e alu_op;
    a_sel_e  a_sel;
    b_sel_e  b_sel;
    logic    br_un;  // Unsigned compare for the branch comparator
    fwd_e    fwd_a;
    fwd_e    fwd_b;
  } exec_ctrl_t;

  // Execute to write-back record
  typedef struct packed {
    logic              valid;
    opcode_e           op;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic              rf_we;
    logic              redirect;  // Taken branch or jump
  } wb_t;

  typedef struct packed {
    logic    rf_we;
    wb_sel_e wb_sel;
    ld_sel_e ld_sel;
  } wb_ctrl_t;

endpackage

// File: hw/wb_ctrl_stage.sv
// Write-back control: register write enable, write-back source,
// load extend select and next-PC select
`timescale 1ns/10ps

module wb_ctrl_stage (
  input  rv_ctrl_pkg::wb_t                wb,
  output rv_ctrl_pkg::wb_ctrl_t           wb_ctrl,
  output logic [rv_ctrl_pkg::REG_AW-1:0]  wb_rd,
  output rv_ctrl_pkg::pc_sel_e            pc_sel
);

  logic we;

  assign we = wb.valid && wb.rf_we;

  always_comb begin
    wb_ctrl.rf_we  = we;
    wb_ctrl.wb_sel = rv_ctrl_pkg::WB_ALU;
    wb_ctrl.ld_sel = rv_ctrl_pkg::LD_W;
    if (wb.valid) begin
      case (wb.op)
        rv_ctrl_pkg::OP_LOAD: begin
          wb_ctrl.wb_sel = rv_ctrl_pkg::WB_MEM;
          case (wb.funct3)
            rv_ctrl_pkg::F3_LB:  wb_ctrl.ld_sel = rv_ctrl_pkg::LD_SB;
            rv_ctrl_pkg::F3_LBU: wb_ctrl.ld_sel = rv_ctrl_pkg::LD_UB;
            rv_ctrl_pkg::F3_LH:  wb_ctrl.ld_sel = rv_ctrl_pkg::LD_SH;
            rv_ctrl_pkg::F3_LHU: wb_ctrl.ld_sel = rv_ctrl_pkg::LD_UH;
            default:             wb_ctrl.ld_sel = rv_ctrl_pkg::LD_W;  // LW and reserved codes
          endcase
        end
        rv_ctrl_pkg::OP_JAL,
        rv_ctrl_pkg::OP_JALR: wb_ctrl.wb_sel = rv_ctrl_pkg::WB_PC4;  // Link address
        default:              wb_ctrl.wb_sel = rv_ctrl_pkg::WB_ALU;
      endcase
    end
  end

  assign wb_rd  = we ? wb.rd : '0;  // Zero whenever nothing is written
  assign pc_sel = (wb.valid && wb.redirect) ? rv_ctrl_pkg::PC_TARGET : rv_ctrl_pkg::PC_SEQ;

endmodule
